//--- rtl/taurus_btb_params.svh
/* BTB sizing macros: program counter width, depth and the
   program counter fields that form the row index and the tag */
`ifndef TAURUS_BTB_PARAMS_SVH
`define TAURUS_BTB_PARAMS_SVH

`define BTB_PC_WIDTH    32
`define BTB_DEPTH       16

// Index sits just above the instruction alignment bits
`define BTB_INDEX_LSB   2
`define BTB_INDEX_BITS  4
`define BTB_TAG_LSB     (`BTB_INDEX_LSB + `BTB_INDEX_BITS)
`define BTB_TAG_BITS    (`BTB_PC_WIDTH - `BTB_TAG_LSB)

`endif

//--- rtl/taurus_btb_pkg.sv
/* BTB package with the stored entry type */
`include "taurus_btb_params.svh"

package taurus_btb_pkg;

    // One BTB row, written as a whole
    //   valid  entry holds a real branch
    //   tag    program counter bits above the index
    //   target full branch target address
    typedef struct packed {
        logic                       valid;
        logic [`BTB_TAG_BITS-1:0]   tag;
        logic [`BTB_PC_WIDTH-1:0]   target;
    } btb_entry_t;

endpackage

//--- rtl/btb_array_if.sv
/* Array port between the index stage, the flip-flop RAM and the match stage */
`timescale 1ns/1ps
`include "taurus_btb_params.svh"

interface btb_array_if;
    import taurus_btb_pkg::*;

    logic [`BTB_DEPTH-1:0]  row_sel;
    logic                   en;
    logic                   we;
    btb_entry_t             wdata;
    // Valid while en is high, row chosen by row_sel
    btb_entry_t             rdata;

    modport stage (
        output row_sel, en, we, wdata
    );

    modport ram (
        input  row_sel, en, we, wdata,
        output rdata
    );

    modport monitor (
        input rdata
    );

endinterface

//--- rtl/btb_index_stage.sv
/* BTB index stage: lookup/update arbitration, operation register
   and one-hot row decode */
`timescale 1ns/1ps
`include "taurus_btb_params.svh"

module btb_index_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        lookup_valid,
    input  logic [`BTB_PC_WIDTH-1:0]    lookup_pc,
    input  logic                        update_valid,
    input  logic [`BTB_PC_WIDTH-1:0]    update_pc,
    input  logic [`BTB_PC_WIDTH-1:0]    update_target,
    btb_array_if.stage                  arr,
    output logic                        op_valid,
    output logic                        op_lookup,
    output logic [`BTB_TAG_BITS-1:0]    op_tag
);
    import taurus_btb_pkg::*;

    logic [`BTB_PC_WIDTH-1:0]   sel_pc;
    logic [`BTB_INDEX_BITS-1:0] idx_q;
    logic                       en_q;
    logic                       we_q;
    btb_entry_t                 wdata_q;
    logic [`BTB_DEPTH-1:0]      row_sel;

    // Update owns the single port when both arrive
    assign sel_pc = update_valid ? update_pc : lookup_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q      <= 1'b0;
            we_q      <= 1'b0;
            op_valid  <= 1'b0;
            op_lookup <= 1'b0;
        end else begin
            en_q      <= update_valid | lookup_valid;
            we_q      <= update_valid;
            // A losing lookup still reports, as a miss
            op_valid  <= lookup_valid;
            op_lookup <= lookup_valid & ~update_valid;
        end
    end

    always_ff @(posedge clk) begin
        idx_q   <= sel_pc[`BTB_INDEX_LSB +: `BTB_INDEX_BITS];
        op_tag  <= lookup_pc[`BTB_TAG_LSB +: `BTB_TAG_BITS];
        wdata_q <= '{valid:  1'b1,
                     tag:    update_pc[`BTB_TAG_LSB +: `BTB_TAG_BITS],
                     target: update_target};
    end

    // No row selected while idle
    always_comb begin
        row_sel = '0;
        if (en_q) begin
            row_sel[idx_q] = 1'b1;
        end
    end

    assign arr.row_sel = row_sel;
    assign arr.en      = en_q;
    assign arr.we      = we_q;
    assign arr.wdata   = wdata_q;

endmodule

//--- rtl/common_dffram_1a1w1r.sv
/* Flip-flop RAM, one address port with one-hot row select,
   resettable rows and an OR-reduced combinational read */
`timescale 1ns/1ps

module common_dffram_1a1w1r #(
    parameter int RAM_DATA_WIDTH = 1,
    parameter int RAM_DEPTH      = 1
) (
    input  logic    clk,
    input  logic    rst_n,
    btb_array_if.ram port
);

    logic [RAM_DATA_WIDTH-1:0]  wdata_bits;
    logic [RAM_DATA_WIDTH-1:0]  row_out [RAM_DEPTH];
    logic [RAM_DATA_WIDTH-1:0]  rdata_bits;

    // Entries are raw bits here
    assign wdata_bits = port.wdata;

    for (genvar i = 0; i < RAM_DEPTH; i++) begin : g_row
        logic                       row_we;
        logic                       row_rd;
        logic [RAM_DATA_WIDTH-1:0]  row_q;

        assign row_we = port.en & port.we & port.row_sel[i];
        assign row_rd = port.en & port.row_sel[i];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                row_q <= '0;
            end else if (row_we) begin
                row_q <= wdata_bits;
            end
        end

        // Unselected rows contribute zero to the OR tree
        assign row_out[i] = row_q & {RAM_DATA_WIDTH{row_rd}};
    end

    always_comb begin
        rdata_bits = '0;
        for (int r = 0; r < RAM_DEPTH; r++) begin
            rdata_bits = rdata_bits | row_out[r];
        end
    end

    assign port.rdata = rdata_bits;

    // Two selected rows would OR their contents together
    a_row_sel_onehot0: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(port.row_sel)
    );

endmodule

//--- rtl/btb_match_stage.sv
/* BTB match stage: tag compare and registered prediction */
`timescale 1ns/1ps
`include "taurus_btb_params.svh"

module btb_match_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    btb_array_if.monitor                arr,
    input  logic                        op_valid,
    input  logic                        op_lookup,
    input  logic [`BTB_TAG_BITS-1:0]    op_tag,
    output logic                        pred_valid,
    output logic                        pred_hit,
    output logic [`BTB_PC_WIDTH-1:0]    pred_target
);

    logic hit;

    // Only a lookup that won the port may hit
    assign hit = op_lookup & arr.rdata.valid & (arr.rdata.tag == op_tag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
            pred_hit   <= 1'b0;
        end else begin
            pred_valid <= op_valid;
            pred_hit   <= hit;
        end
    end

    // Target reads as zero on a miss
    always_ff @(posedge clk) begin
        pred_target <= hit ? arr.rdata.target : '0;
    end

    a_hit_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) pred_hit |-> pred_valid
    );

endmodule

//--- rtl/taurus_btb.sv
/* Direct-mapped branch target buffer top level:
   index stage, flip-flop RAM and match stage */
`timescale 1ns/1ps
`include "taurus_btb_params.svh"

module taurus_btb (
    input  logic                        clk,
    input  logic                        rst_n,

    // Lookup from fetch
    input  logic                        lookup_valid,
    input  logic [`BTB_PC_WIDTH-1:0]    lookup_pc,

    // Update from branch resolution
    input  logic                        update_valid,
    input  logic [`BTB_PC_WIDTH-1:0]    update_pc,
    input  logic [`BTB_PC_WIDTH-1:0]    update_target,

    // Prediction, two cycles after the lookup
    output logic                        pred_valid,
    output logic                        pred_hit,
    output logic [`BTB_PC_WIDTH-1:0]    pred_target
);
    import taurus_btb_pkg::*;

    logic                       op_valid;
    logic                       op_lookup;
    logic [`BTB_TAG_BITS-1:0]   op_tag;

    btb_array_if arr_if ();

    btb_index_stage u_index (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_valid  (lookup_valid),
        .lookup_pc     (lookup_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_target (update_target),
        .arr           (arr_if.stage),
        .op_valid      (op_valid),
        .op_lookup     (op_lookup),
        .op_tag        (op_tag)
    );

    common_dffram_1a1w1r #(
        .RAM_DATA_WIDTH ($bits(btb_entry_t)),
        .RAM_DEPTH      (`BTB_DEPTH)
    ) u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (arr_if.ram)
    );

    btb_match_stage u_match (
        .clk         (clk),
        .rst_n       (rst_n),
        .arr         (arr_if.monitor),
        .op_valid    (op_valid),
        .op_lookup   (op_lookup),
        .op_tag      (op_tag),
        .pred_valid  (pred_valid),
        .pred_hit    (pred_hit),
        .pred_target (pred_target)
    );

endmodule

//--- test/tb_taurus_btb.sv
/* BTB testbench: directed stimulus table with expected predictions,
   then random lookups and updates checked against a model of the array */
`timescale 1ns/1ps
`include "taurus_btb_params.svh"

module tb_taurus_btb;

    localparam int  CLK_PERIOD   = 4;
    localparam int  RESET_CYCLES = 4;
    localparam int  NUM_ROWS     = 22;
    localparam int  NUM_RAND     = 64;
    localparam int  DRAIN_CYCLES = 8;
    localparam int  MARGIN       = 20;
    // Drive at edge+1, sample edge +3, result checked at the falling edge after two more edges
    localparam time LATENCY_NS   = 9;
    localparam int  WATCHDOG_NS  = (RESET_CYCLES + NUM_ROWS + NUM_RAND + MARGIN) * CLK_PERIOD;

    localparam logic [`BTB_PC_WIDTH-1:0] Z  = 32'h0000_0000;
    localparam logic [`BTB_PC_WIDTH-1:0] P1 = 32'h0000_1004;
    localparam logic [`BTB_PC_WIDTH-1:0] P2 = 32'h0000_2008;
    localparam logic [`BTB_PC_WIDTH-1:0] P3 = 32'h0000_300c;
    // Same index as P1, other tag
    localparam logic [`BTB_PC_WIDTH-1:0] P4 = 32'h0000_5004;
    localparam logic [`BTB_PC_WIDTH-1:0] P5 = 32'h0000_4010;
    localparam logic [`BTB_PC_WIDTH-1:0] P6 = 32'h0000_6014;
    localparam logic [`BTB_PC_WIDTH-1:0] T1 = 32'h8000_0100;
    localparam logic [`BTB_PC_WIDTH-1:0] T2 = 32'h8000_0200;
    localparam logic [`BTB_PC_WIDTH-1:0] T4 = 32'h8000_0400;
    localparam logic [`BTB_PC_WIDTH-1:0] T5 = 32'h8000_0500;
    localparam logic [`BTB_PC_WIDTH-1:0] T6 = 32'h8000_0600;

    typedef struct packed {
        logic                       lv;
        logic [`BTB_PC_WIDTH-1:0]   lpc;
        logic                       uv;
        logic [`BTB_PC_WIDTH-1:0]   upc;
        logic [`BTB_PC_WIDTH-1:0]   utgt;
        logic                       hit;
        logic [`BTB_PC_WIDTH-1:0]   tgt;
    } stim_row_t;

    logic                       clk;
    logic                       rst_n;
    logic                       lookup_valid;
    logic [`BTB_PC_WIDTH-1:0]   lookup_pc;
    logic                       update_valid;
    logic [`BTB_PC_WIDTH-1:0]   update_pc;
    logic [`BTB_PC_WIDTH-1:0]   update_target;
    logic                       pred_valid;
    logic                       pred_hit;
    logic [`BTB_PC_WIDTH-1:0]   pred_target;

    stim_row_t                  stim [NUM_ROWS];
    logic                       exp_hit_q [$];
    logic [`BTB_PC_WIDTH-1:0]   exp_tgt_q [$];
    time                        exp_due_q [$];

    logic                       model_valid  [`BTB_DEPTH];
    logic [`BTB_TAG_BITS-1:0]   model_tag    [`BTB_DEPTH];
    logic [`BTB_PC_WIDTH-1:0]   model_target [`BTB_DEPTH];

    int value_errors;
    int protocol_errors;

    taurus_btb DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_valid  (lookup_valid),
        .lookup_pc     (lookup_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_target (update_target),
        .pred_valid    (pred_valid),
        .pred_hit      (pred_hit),
        .pred_target   (pred_target)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [`BTB_PC_WIDTH-1:0] make_pc(input logic [`BTB_TAG_BITS-1:0] tag,
                                                         input logic [`BTB_INDEX_BITS-1:0] idx);
        return {tag, idx, {`BTB_INDEX_LSB{1'b0}}};
    endfunction

    task automatic model_lookup(input logic [`BTB_PC_WIDTH-1:0] pc, output logic hit,
                                output logic [`BTB_PC_WIDTH-1:0] tgt);
        logic [`BTB_INDEX_BITS-1:0] idx;
        idx = pc[`BTB_INDEX_LSB +: `BTB_INDEX_BITS];
        hit = model_valid[idx] && (model_tag[idx] == pc[`BTB_TAG_LSB +: `BTB_TAG_BITS]);
        tgt = hit ? model_target[idx] : '0;
    endtask

    // One cycle of stimulus, driven just after the rising edge
    task automatic drive_cycle(input stim_row_t row);
        logic [`BTB_INDEX_BITS-1:0] idx;
        @(posedge clk);
        #1;
        lookup_valid  = row.lv;
        lookup_pc     = row.lpc;
        update_valid  = row.uv;
        update_pc     = row.upc;
        update_target = row.utgt;
        if (row.lv) begin
            exp_hit_q.push_back(row.hit);
            exp_tgt_q.push_back(row.tgt);
            exp_due_q.push_back($time + LATENCY_NS);
        end
        if (row.uv) begin
            idx               = row.upc[`BTB_INDEX_LSB +: `BTB_INDEX_BITS];
            model_valid[idx]  = 1'b1;
            model_tag[idx]    = row.upc[`BTB_TAG_LSB +: `BTB_TAG_BITS];
            model_target[idx] = row.utgt;
        end
    endtask

    task automatic load_table();
        // lookup, lookup pc, update, update pc, update target, hit, target
        stim[0]  = '{1'b1, P1, 1'b0, Z,  Z,  1'b0, Z};
        stim[1]  = '{1'b1, P2, 1'b0, Z,  Z,  1'b0, Z};
        stim[2]  = '{1'b1, P3, 1'b0, Z,  Z,  1'b0, Z};
        stim[3]  = '{1'b0, Z,  1'b1, P1, T1, 1'b0, Z};
        stim[4]  = '{1'b0, Z,  1'b0, Z,  Z,  1'b0, Z};
        stim[5]  = '{1'b1, P1, 1'b0, Z,  Z,  1'b1, T1};
        stim[6]  = '{1'b0, Z,  1'b1, P2, T2, 1'b0, Z};
        stim[7]  = '{1'b1, P2, 1'b0, Z,  Z,  1'b1, T2};
        stim[8]  = '{1'b1, P4, 1'b0, Z,  Z,  1'b0, Z};
        stim[9]  = '{1'b0, Z,  1'b1, P4, T4, 1'b0, Z};
        stim[10] = '{1'b1, P1, 1'b0, Z,  Z,  1'b0, Z};
        stim[11] = '{1'b1, P4, 1'b0, Z,  Z,  1'b1, T4};
        // Lookup loses the port to an update
        stim[12] = '{1'b1, P5, 1'b1, P5, T5, 1'b0, Z};
        stim[13] = '{1'b1, P5, 1'b0, Z,  Z,  1'b1, T5};
        // Stored entry, but the lookup loses the port and misses
        stim[14] = '{1'b1, P5, 1'b1, P5, T6, 1'b0, Z};
        stim[15] = '{1'b1, P5, 1'b0, Z,  Z,  1'b1, T6};
        stim[16] = '{1'b1, P2, 1'b0, Z,  Z,  1'b1, T2};
        stim[17] = '{1'b1, P4, 1'b0, Z,  Z,  1'b1, T4};
        stim[18] = '{1'b1, P3, 1'b0, Z,  Z,  1'b0, Z};
        stim[19] = '{1'b1, P6, 1'b0, Z,  Z,  1'b0, Z};
        stim[20] = '{1'b1, P5, 1'b0, Z,  Z,  1'b1, T6};
        stim[21] = '{1'b0, Z,  1'b0, Z,  Z,  1'b0, Z};
    endtask

    task automatic check_outputs();
        logic                       e_hit;
        logic [`BTB_PC_WIDTH-1:0]   e_tgt;
        time                        due;
        if (pred_valid) begin
            if (exp_hit_q.size() == 0) begin
                $display("prediction at %0t ns with no lookup pending", $time);
                protocol_errors++;
            end else begin
                e_hit = exp_hit_q.pop_front();
                e_tgt = exp_tgt_q.pop_front();
                due   = exp_due_q.pop_front();
                if (due != $time) begin
                    $display("error at %0t ns: pred_valid time expected %0t got %0t",
                             $time, due, $time);
                    value_errors++;
                end
                if (pred_hit !== e_hit) begin
                    $display("error at %0t ns: pred_hit expected %0b got %0b",
                             $time, e_hit, pred_hit);
                    value_errors++;
                end
                if (pred_target !== e_tgt) begin
                    $display("error at %0t ns: pred_target expected %h got %h",
                             $time, e_tgt, pred_target);
                    value_errors++;
                end
            end
        end else if (exp_due_q.size() != 0 && exp_due_q[0] <= $time) begin
            $display("lookup due at %0t ns produced no prediction", exp_due_q[0]);
            void'(exp_hit_q.pop_front());
            void'(exp_tgt_q.pop_front());
            void'(exp_due_q.pop_front());
            protocol_errors++;
        end
    endtask

    initial begin : output_check
        forever begin
            @(negedge clk);
            if (rst_n) begin
                check_outputs();
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, simulation stopped", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        logic [31:0]    rng;
        stim_row_t      row;
        int             waited;
        rst_n           = 1'b0;
        lookup_valid    = 1'b0;
        lookup_pc       = '0;
        update_valid    = 1'b0;
        update_pc       = '0;
        update_target   = '0;
        value_errors    = 0;
        protocol_errors = 0;
        rng             = 32'd88357;
        for (int i = 0; i < `BTB_DEPTH; i++) begin
            model_valid[i]  = 1'b0;
            model_tag[i]    = '0;
            model_target[i] = '0;
        end
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (pred_valid !== 1'b0 || pred_hit !== 1'b0) begin
            $display("prediction outputs not low after reset");
            protocol_errors++;
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            drive_cycle(stim[i]);
        end

        // Random lookups on rows 8 to 11, updates on about half the cycles
        for (int n = 0; n < NUM_RAND; n++) begin
            rng      = xorshift32(rng);
            row.lv   = 1'b1;
            row.lpc  = make_pc({24'h000004, rng[1:0]}, {2'b10, rng[3:2]});
            row.uv   = rng[6];
            row.upc  = make_pc({24'h000004, rng[9:8]}, {2'b10, rng[11:10]});
            rng      = xorshift32(rng);
            row.utgt = {rng[31:2], 2'b00};
            if (row.uv) begin
                row.hit = 1'b0;
                row.tgt = '0;
            end else begin
                model_lookup(row.lpc, row.hit, row.tgt);
            end
            drive_cycle(row);
        end
        drive_cycle('0);

        waited = 0;
        while (exp_hit_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (exp_hit_q.size() != 0) begin
            $display("%0d lookups still waiting for a prediction", exp_hit_q.size());
            protocol_errors += exp_hit_q.size();
        end

        $display("errors: %0d total, %0d value, %0d protocol",
                 value_errors + protocol_errors, value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- taurus_btb.f
+incdir+rtl
rtl/taurus_btb_pkg.sv
rtl/btb_array_if.sv
rtl/btb_index_stage.sv
rtl/common_dffram_1a1w1r.sv
rtl/btb_match_stage.sv
rtl/taurus_btb.sv
test/tb_taurus_btb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_taurus_btb
FILELIST   := taurus_btb.f
BUILD_DIR  := obj_dir
LOG        := sim.log

SOURCES := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
